// ==== source/icache_pkg.sv ====
// Instruction cache package: address fields, cache geometry, memory timing, controller states
`default_nettype none

package icache_pkg;

  // ====================================================================
  // Address fields and geometry
  // ====================================================================
  localparam int ADDR_BITS   = 12;
  localparam int WORD_BITS   = 32;
  localparam int OFFSET_BITS = 4;
  localparam int INDEX_BITS  = 4;
  localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

  localparam int LINES       = 1 << INDEX_BITS;
  localparam int LINE_WORDS  = 4;
  localparam int BEAT_BITS   = $clog2(LINE_WORDS);
  localparam int LINE_BITS   = LINE_WORDS * WORD_BITS;

  // ====================================================================
  // Backing memory and statistics
  // ====================================================================
  localparam int MEM_WORDS     = 1024;
  localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
  // Request edge to first beat
  localparam int MEM_LATENCY   = 3;
  localparam int LAT_BITS      = $clog2(MEM_LATENCY + 1);

  localparam int STAT_BITS   = 16;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    CHK,
    REFILL,
    RESP
  } icache_state_t;

endpackage

`default_nettype wire

// ==== source/refill_if.sv ====
// Refill bus interface: line request and four-beat return data, controller and memory modports
`timescale 1ns/1ps
`default_nettype none

interface refill_if (
  input wire logic clk
);
  import icache_pkg::*;

  // Single-cycle line request
  logic                     req;
  logic [MEM_ADDR_BITS-1:0] line_addr;

  // Return beats, word 0 first
  logic                     beat_valid;
  logic [WORD_BITS-1:0]     beat_data;

  modport ctrl (
    input  clk,
    output req,
    output line_addr,
    input  beat_valid,
    input  beat_data
  );

  modport mem (
    input  clk,
    input  req,
    input  line_addr,
    output beat_valid,
    output beat_data
  );

endinterface

`default_nettype wire

// ==== source/icache_tag_array.sv ====
// Tag store: one tag per cache line, registered read, clocked write
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array (
  input  wire logic                            clk,
  input  wire logic [icache_pkg::INDEX_BITS-1:0] index,
  input  wire logic                            rd_en,
  input  wire logic                            wr_en,
  input  wire logic [icache_pkg::TAG_BITS-1:0]   wr_tag,
  output logic      [icache_pkg::TAG_BITS-1:0]   rd_tag
);
  import icache_pkg::*;

  logic [TAG_BITS-1:0] tags [LINES];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tags[index] <= wr_tag;
    end
  end

  // Read data holds until the next read enable
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_tag <= tags[index];
    end
  end

endmodule

`default_nettype wire

// ==== source/icache_data_array.sv ====
// Line store: four words per line, whole-line write and registered whole-line read
`timescale 1ns/1ps
`default_nettype none

module icache_data_array (
  input  wire logic                              clk,
  input  wire logic [icache_pkg::INDEX_BITS-1:0] index,
  input  wire logic                              rd_en,
  input  wire logic                              wr_en,
  input  wire logic [icache_pkg::LINE_BITS-1:0]  wr_line,
  output logic      [icache_pkg::LINE_BITS-1:0]  rd_line
);
  import icache_pkg::*;

  logic [LINE_BITS-1:0] lines [LINES];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      lines[index] <= wr_line;
    end
  end

  // Word 0 sits in the low bits of a line
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_line <= lines[index];
    end
  end

endmodule

`default_nettype wire

// ==== source/icache_ctrl.sv ====
// Cache controller: request capture, valid bits, hit check FSM, line refill, response, statistics
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  wire logic                              clk,
  input  wire logic                              rstn,
  // Fetch port
  input  wire logic                              fetch_req,
  input  wire logic [icache_pkg::ADDR_BITS-1:0]  fetch_addr,
  input  wire logic                              flush,
  output logic                                   busy,
  output logic                                   rsp_valid,
  output logic      [icache_pkg::WORD_BITS-1:0]  rsp_data,
  output logic                                   rsp_hit,
  // Arrays, shared index and enables
  output logic      [icache_pkg::INDEX_BITS-1:0] index,
  output logic                                   rd_en,
  output logic                                   wr_en,
  output logic      [icache_pkg::TAG_BITS-1:0]   wr_tag,
  input  wire logic [icache_pkg::TAG_BITS-1:0]   rd_tag,
  output logic      [icache_pkg::LINE_BITS-1:0]  wr_line,
  input  wire logic [icache_pkg::LINE_BITS-1:0]  rd_line,
  // Refill bus
  refill_if.ctrl                                 refill,
  // Statistics
  output logic      [icache_pkg::STAT_BITS-1:0]  stat_req,
  output logic      [icache_pkg::STAT_BITS-1:0]  stat_hit,
  output logic      [icache_pkg::STAT_BITS-1:0]  stat_miss
);
  import icache_pkg::*;

  icache_state_t state;
  icache_state_t state_nxt;

  logic [ADDR_BITS-1:0]  addr_r;
  logic [TAG_BITS-1:0]   tag_r;
  logic [INDEX_BITS-1:0] idx_r;
  logic [BEAT_BITS-1:0]  word_r;
  logic [LINES-1:0]      valid;
  logic [BEAT_BITS-1:0]  beat_cnt;
  logic [LINE_BITS-1:0]  line_buf;
  logic [LINE_BITS-1:0]  line_nxt;
  logic                  accept;
  logic                  hit;
  logic                  last_beat;
  logic                  line_wr;

  function automatic logic [WORD_BITS-1:0] pick_word(input logic [LINE_BITS-1:0] line,
                                                     input logic [BEAT_BITS-1:0] sel);
    return line[sel*WORD_BITS +: WORD_BITS];
  endfunction

  assign tag_r  = addr_r[ADDR_BITS-1 -: TAG_BITS];
  assign idx_r  = addr_r[OFFSET_BITS +: INDEX_BITS];
  assign word_r = addr_r[OFFSET_BITS-BEAT_BITS +: BEAT_BITS];

  // ====================================================================
  // Request capture
  // ====================================================================
  assign busy   = (state != IDLE) || rsp_valid;
  assign accept = fetch_req && !busy;

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_r <= fetch_addr;
    end
  end

  // Arrays are read straight from the fetch address
  assign index   = accept ? fetch_addr[OFFSET_BITS +: INDEX_BITS] : idx_r;
  assign rd_en   = accept;
  assign wr_en   = line_wr;
  assign wr_tag  = tag_r;
  assign wr_line = line_buf;

  assign hit = valid[idx_r] && (rd_tag == tag_r);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else if (flush && !busy) begin
      valid <= '0;
    end else if (line_wr) begin
      valid[idx_r] <= 1'b1;
    end
  end

  // ====================================================================
  // State machine
  // ====================================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    state_nxt = accept ? CHK : IDLE;
      CHK:     state_nxt = hit ? RESP : REFILL;
      REFILL:  state_nxt = last_beat ? IDLE : REFILL;
      RESP:    state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  // Refill line assembly
  assign refill.req       = (state == CHK) && !hit;
  assign refill.line_addr = {tag_r, idx_r, {BEAT_BITS{1'b0}}};

  assign line_nxt  = {refill.beat_data, line_buf[LINE_BITS-1:WORD_BITS]};
  assign last_beat = (state == REFILL) && refill.beat_valid &&
                     (beat_cnt == BEAT_BITS'(LINE_WORDS - 1));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_cnt <= '0;
      line_wr  <= 1'b0;
    end else begin
      line_wr <= last_beat;
      if ((state == REFILL) && refill.beat_valid) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == REFILL) && refill.beat_valid) begin
      line_buf <= line_nxt;
    end
  end

  // ====================================================================
  // Response and statistics
  // ====================================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= (state == RESP) || last_beat;
    end
  end

  // Miss data bypasses the array
  always_ff @(posedge clk) begin
    if (state == RESP) begin
      rsp_data <= pick_word(rd_line, word_r);
      rsp_hit  <= 1'b1;
    end else if (last_beat) begin
      rsp_data <= pick_word(line_nxt, word_r);
      rsp_hit  <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stat_req  <= '0;
      stat_hit  <= '0;
      stat_miss <= '0;
    end else begin
      if (accept) begin
        stat_req <= stat_req + 1'b1;
      end
      if ((state == CHK) && hit) begin
        stat_hit <= stat_hit + 1'b1;
      end
      if (last_beat) begin
        stat_miss <= stat_miss + 1'b1;
      end
    end
  end

  // A response ends an outstanding fetch and lasts one cycle
  a_rsp_source: assert property (@(posedge clk) disable iff (!rstn)
    rsp_valid |-> $past(busy) && !$past(rsp_valid));

  // Memory only returns beats to an outstanding refill
  a_beat_in_refill: assert property (@(posedge clk) disable iff (!rstn)
    refill.beat_valid |-> (state == REFILL));

endmodule

`default_nettype wire

// ==== source/refill_mem.sv ====
// Instruction memory: external load port and fixed-latency four-beat line refill
`timescale 1ns/1ps
`default_nettype none

module refill_mem (
  input  wire logic                                 clk,
  input  wire logic                                 rstn,
  input  wire logic                                 load_en,
  input  wire logic [icache_pkg::MEM_ADDR_BITS-1:0] load_addr,
  input  wire logic [icache_pkg::WORD_BITS-1:0]     load_data,
  refill_if.mem                                     refill
);
  import icache_pkg::*;

  logic [WORD_BITS-1:0]     mem [MEM_WORDS];
  logic [MEM_ADDR_BITS-1:0] rd_ptr;
  logic                     waiting;
  logic [LAT_BITS-1:0]      lat_cnt;
  logic [BEAT_BITS-1:0]     beat_cnt;
  logic                     first_beat;
  logic                     next_beat;

  // Program image
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  assign first_beat = waiting && (lat_cnt == '0);
  assign next_beat  = refill.beat_valid && (beat_cnt != BEAT_BITS'(LINE_WORDS - 1));

  // ====================================================================
  // Latency and burst counters
  // ====================================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      waiting           <= 1'b0;
      lat_cnt           <= '0;
      beat_cnt          <= '0;
      refill.beat_valid <= 1'b0;
    end else if (refill.req) begin
      waiting <= 1'b1;
      lat_cnt <= LAT_BITS'(MEM_LATENCY - 1);
    end else if (waiting) begin
      if (first_beat) begin
        waiting           <= 1'b0;
        beat_cnt          <= '0;
        refill.beat_valid <= 1'b1;
      end else begin
        lat_cnt <= lat_cnt - 1'b1;
      end
    end else if (refill.beat_valid) begin
      beat_cnt <= beat_cnt + 1'b1;
      if (!next_beat) begin
        refill.beat_valid <= 1'b0;
      end
    end
  end

  // Words stream out in address order
  always_ff @(posedge clk) begin
    if (refill.req) begin
      rd_ptr <= refill.line_addr;
    end else if (first_beat || next_beat) begin
      refill.beat_data <= mem[rd_ptr];
      rd_ptr           <= rd_ptr + 1'b1;
    end
  end

  a_no_req_in_burst: assert property (@(posedge clk) disable iff (!rstn)
    refill.req |-> !waiting && !refill.beat_valid);

endmodule

`default_nettype wire

// ==== source/icache_top.sv ====
// Cache subsystem top: controller, tag and data arrays, refill bus and backing memory
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire logic                                 clk,
  input  wire logic                                 rstn,
  input  wire logic                                 fetch_req,
  input  wire logic [icache_pkg::ADDR_BITS-1:0]     fetch_addr,
  output logic                                      busy,
  output logic                                      rsp_valid,
  output logic      [icache_pkg::WORD_BITS-1:0]     rsp_data,
  output logic                                      rsp_hit,
  input  wire logic                                 flush,
  input  wire logic                                 load_en,
  input  wire logic [icache_pkg::MEM_ADDR_BITS-1:0] load_addr,
  input  wire logic [icache_pkg::WORD_BITS-1:0]     load_data,
  output logic      [icache_pkg::STAT_BITS-1:0]     stat_req,
  output logic      [icache_pkg::STAT_BITS-1:0]     stat_hit,
  output logic      [icache_pkg::STAT_BITS-1:0]     stat_miss
);
  import icache_pkg::*;

  logic [INDEX_BITS-1:0] index;
  logic                  rd_en;
  logic                  wr_en;
  logic [TAG_BITS-1:0]   wr_tag;
  logic [TAG_BITS-1:0]   rd_tag;
  logic [LINE_BITS-1:0]  wr_line;
  logic [LINE_BITS-1:0]  rd_line;

  refill_if u_refill_if (.clk(clk));

  icache_ctrl u_icache_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .flush      (flush),
    .busy       (busy),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_hit    (rsp_hit),
    .index      (index),
    .rd_en      (rd_en),
    .wr_en      (wr_en),
    .wr_tag     (wr_tag),
    .rd_tag     (rd_tag),
    .wr_line    (wr_line),
    .rd_line    (rd_line),
    .refill     (u_refill_if.ctrl),
    .stat_req   (stat_req),
    .stat_hit   (stat_hit),
    .stat_miss  (stat_miss)
  );

  icache_tag_array u_icache_tag_array (
    .clk    (clk),
    .index  (index),
    .rd_en  (rd_en),
    .wr_en  (wr_en),
    .wr_tag (wr_tag),
    .rd_tag (rd_tag)
  );

  icache_data_array u_icache_data_array (
    .clk     (clk),
    .index   (index),
    .rd_en   (rd_en),
    .wr_en   (wr_en),
    .wr_line (wr_line),
    .rd_line (rd_line)
  );

  refill_mem u_refill_mem (
    .clk       (clk),
    .rstn      (rstn),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .refill    (u_refill_if.mem)
  );

endmodule

`default_nettype wire

// ==== test/tb_icache.sv ====
// Testbench for the instruction cache: memory preload, table of fetches and flushes, model checks
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
  import icache_pkg::*;

  localparam int OP_FETCH   = 0;
  localparam int OP_FLUSH   = 1;
  // Fetch plus an extra request while busy
  localparam int OP_POKE    = 2;
  localparam int MISS_WORST = MEM_LATENCY + LINE_WORDS + 4;

  logic                     clk = 1'b0;
  logic                     rstn;
  logic                     fetch_req;
  logic [ADDR_BITS-1:0]     fetch_addr;
  logic                     busy;
  logic                     rsp_valid;
  logic [WORD_BITS-1:0]     rsp_data;
  logic                     rsp_hit;
  logic                     flush;
  logic                     load_en;
  logic [MEM_ADDR_BITS-1:0] load_addr;
  logic [WORD_BITS-1:0]     load_data;
  logic [STAT_BITS-1:0]     stat_req;
  logic [STAT_BITS-1:0]     stat_hit;
  logic [STAT_BITS-1:0]     stat_miss;

  // Reference copies of the memory image and the tag state
  logic [WORD_BITS-1:0] mem_model [MEM_WORDS];
  logic [LINES-1:0]     model_valid;
  logic [TAG_BITS-1:0]  model_tag [LINES];
  int                   op_q [$];
  logic [ADDR_BITS-1:0] addr_q [$];
  integer               seed;
  int                   errors;
  int                   rsp_count;
  int                   exp_req;
  int                   exp_hit;
  int                   exp_miss;
  int                   cycles;
  int                   cycle_limit = 1 << 20;

  icache_top u_icache_top (.*);

  always #2 clk = ~clk;

  // Responses counted on the falling edge
  always @(negedge clk) begin
    if (rstn && rsp_valid) begin
      rsp_count++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles without finishing", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic add_entry(input int op, input logic [ADDR_BITS-1:0] addr);
    op_q.push_back(op);
    addr_q.push_back(addr);
  endtask

  task automatic report_mismatch(input string name, input logic [WORD_BITS-1:0] got,
                                 input logic [WORD_BITS-1:0] exp);
    $display("FAIL %0t ns %s got %0h expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic do_fetch(input logic [ADDR_BITS-1:0] addr, input bit poke);
    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag;
    logic [WORD_BITS-1:0]  exp_data;
    logic                  exp_hit_now;
    int                    n;
    idx         = addr[OFFSET_BITS +: INDEX_BITS];
    tag         = addr[ADDR_BITS-1 -: TAG_BITS];
    exp_data    = mem_model[addr[ADDR_BITS-1:2]];
    exp_hit_now = model_valid[idx] && (model_tag[idx] == tag);
    while (busy) begin
      step();
    end
    fetch_req  = 1'b1;
    fetch_addr = addr;
    step();
    // Second request lands in the check cycle, busy is high
    fetch_req  = poke;
    fetch_addr = addr ^ 12'h800;
    n = 0;
    while (!rsp_valid) begin
      if (!busy) begin
        $display("%0t ns: busy low while a fetch to %h is outstanding", $time, addr);
        errors++;
      end
      step();
      fetch_req = 1'b0;
      n++;
    end
    if (rsp_data !== exp_data) begin
      report_mismatch("rsp_data", rsp_data, exp_data);
    end
    if (rsp_hit !== exp_hit_now) begin
      report_mismatch("rsp_hit", rsp_hit, exp_hit_now);
    end
    if (exp_hit_now && (n != 2)) begin
      $display("%0t ns: hit to %h answered after %0d cycles instead of 2", $time, addr, n);
      errors++;
    end
    model_valid[idx] = 1'b1;
    model_tag[idx]   = tag;
    exp_req++;
    if (exp_hit_now) begin
      exp_hit++;
    end else begin
      exp_miss++;
    end
    step();
    if (busy) begin
      $display("%0t ns: busy still high the cycle after a response", $time);
      errors++;
    end
  endtask

  task automatic do_flush();
    while (busy) begin
      step();
    end
    flush = 1'b1;
    step();
    flush       = 1'b0;
    model_valid = '0;
  endtask

  // ====================================================================
  // Stimulus
  // ====================================================================
  initial begin
    seed        = 32'hc16e00c0;
    rstn        = 1'b0;
    fetch_req   = 1'b0;
    fetch_addr  = '0;
    flush       = 1'b0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    model_valid = '0;

    // Cold miss, repeat hit, rest of the line
    add_entry(OP_FETCH, 12'h040);
    add_entry(OP_FETCH, 12'h040);
    add_entry(OP_FETCH, 12'h044);
    add_entry(OP_FETCH, 12'h048);
    add_entry(OP_FETCH, 12'h04c);
    // Same index, different tags
    add_entry(OP_FETCH, 12'h150);
    add_entry(OP_FETCH, 12'h350);
    add_entry(OP_FETCH, 12'h150);
    add_entry(OP_FETCH, 12'h354);
    add_entry(OP_FLUSH, 12'h000);
    add_entry(OP_FETCH, 12'h044);
    add_entry(OP_FETCH, 12'h040);
    add_entry(OP_POKE,  12'h2a8);
    add_entry(OP_POKE,  12'h2a0);
    add_entry(OP_FETCH, 12'hffc);
    add_entry(OP_FETCH, 12'hff0);
    add_entry(OP_FETCH, 12'h000);
    cycle_limit = 5 + MEM_WORDS + op_q.size() * 2 * (MISS_WORST + 4) + 100;

    repeat (5) @(posedge clk);
    #1;
    rstn = 1'b1;
    if ((busy !== 1'b0) || (rsp_valid !== 1'b0)) begin
      $display("%0t ns: busy or rsp_valid high after reset", $time);
      errors++;
    end
    if ((stat_req | stat_hit | stat_miss) !== '0) begin
      $display("%0t ns: statistics counters not zero after reset", $time);
      errors++;
    end

    // Program image
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = $random(seed);
      load_en      = 1'b1;
      load_addr    = MEM_ADDR_BITS'(i);
      load_data    = mem_model[i];
      step();
    end
    load_en = 1'b0;

    foreach (op_q[k]) begin
      if (op_q[k] == OP_FLUSH) begin
        do_flush();
      end else begin
        do_fetch(addr_q[k], op_q[k] == OP_POKE);
      end
    end
    repeat (4) step();

    if (stat_req !== STAT_BITS'(exp_req)) begin
      report_mismatch("stat_req", stat_req, exp_req);
    end
    if (stat_hit !== STAT_BITS'(exp_hit)) begin
      report_mismatch("stat_hit", stat_hit, exp_hit);
    end
    if (stat_miss !== STAT_BITS'(exp_miss)) begin
      report_mismatch("stat_miss", stat_miss, exp_miss);
    end
    if (rsp_count != exp_req) begin
      report_mismatch("rsp_valid pulses", rsp_count, exp_req);
    end

    $display("Summary: %0d errors, %0d requests, %0d hits, %0d misses, %0d responses",
             errors, exp_req, exp_hit, exp_miss, rsp_count);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/icache_pkg.sv
source/refill_if.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_ctrl.sv
source/refill_mem.sv
source/icache_top.sv
test/tb_icache.sv
